// ==== fb_pkg.sv ====
package fb_pkg;

   // framebuffer geometry
   localparam int FB_COLS        = 200;
   localparam int FB_ROWS        = 150;
   localparam int FB_DEPTH       = FB_COLS * FB_ROWS;
   localparam int FB_ADDR_W      = 15;
   localparam int PIX_SCALE_LOG2 = 2;            // 4x4 screen pixels per stored pixel

   // 800x600 horizontal timing
   localparam int H_VISIBLE = 800;
   localparam int H_FRONT   = 56;
   localparam int H_SYNC    = 120;
   localparam int H_BACK    = 64;
   localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

   // vertical timing, in lines
   localparam int V_VISIBLE = 600;
   localparam int V_FRONT   = 37;
   localparam int V_SYNC    = 6;
   localparam int V_BACK    = 23;
   localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

   localparam int CNT_W        = 11;
   localparam int WQ_DEPTH     = 4;
   localparam int WQ_PTR_W     = $clog2(WQ_DEPTH);
   localparam int SCAN_LATENCY = 3;              // position to o_vga

   typedef enum logic [3:0] {
      OP_NOP = 4'd0,
      OP_LDR = 4'd1,
      OP_LDC = 4'd2,
      OP_LDD = 4'd3
   } fb_opcode_e;

   typedef enum logic [1:0] {
      ST_INIT,
      ST_READY,
      ST_ERROR
   } fb_dec_state_e;

   typedef struct packed {
      logic [3:0] opcode;
      logic [7:0] imm;
   } fb_instr_t;

   typedef struct packed {
      logic r;
      logic g;
      logic b;
   } fb_color_t;

   typedef struct packed {
      logic [FB_ADDR_W-1:0] addr;
      fb_color_t            color;
   } fb_write_t;

   typedef struct packed {
      logic [CNT_W-1:0] h;
      logic [CNT_W-1:0] v;
      logic             visible;
      logic             hsync;
      logic             vsync;
   } vga_pos_t;

   typedef struct packed {
      logic      hsync;
      logic      vsync;
      fb_color_t color;
   } vga_out_t;

endpackage

// ==== fb_instr_decoder.sv ====
`timescale 1ns/1ps

module fb_instr_decoder (
   input  logic              i_clock,
   input  logic              i_reset,
   input  fb_pkg::fb_instr_t i_instr,
   input  logic              i_instr_en,
   output logic              o_wr_valid,
   output fb_pkg::fb_write_t o_wr,
   output logic              o_error
);

   fb_pkg::fb_dec_state_e state;
   logic [7:0]            row;
   logic [7:0]            col;
   logic                  in_range;
   logic [fb_pkg::FB_ADDR_W-1:0] lin_addr;

   assign in_range = (row < 8'(fb_pkg::FB_ROWS)) && (col < 8'(fb_pkg::FB_COLS));
   assign lin_addr = fb_pkg::FB_ADDR_W'(row) * fb_pkg::FB_ADDR_W'(fb_pkg::FB_COLS)
                   + fb_pkg::FB_ADDR_W'(col);

   assign o_error = (state == fb_pkg::ST_ERROR);

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         state      <= fb_pkg::ST_INIT;
         row        <= '0;
         col        <= '0;
         o_wr_valid <= 1'b0;
      end else begin
         o_wr_valid <= 1'b0;
         case (state)
            fb_pkg::ST_INIT: begin
               state <= fb_pkg::ST_READY;
            end
            fb_pkg::ST_READY: begin
               if (i_instr_en) begin
                  case (i_instr.opcode)
                     fb_pkg::OP_NOP: ;
                     fb_pkg::OP_LDR: row <= i_instr.imm;
                     fb_pkg::OP_LDC: col <= i_instr.imm;
                     fb_pkg::OP_LDD: o_wr_valid <= in_range;  // out of range is dropped
                     default: begin
                        state <= fb_pkg::ST_ERROR;
                        row   <= '0;
                        col   <= '0;
                     end
                  endcase
               end
            end
            default: begin  // sticky until reset
               state <= fb_pkg::ST_ERROR;
               row   <= '0;
               col   <= '0;
            end
         endcase
      end
   end

   // payload qualified by o_wr_valid
   always_ff @(posedge i_clock) begin
      if (i_instr_en) begin
         o_wr.addr  <= lin_addr;
         o_wr.color <= fb_pkg::fb_color_t'(i_instr.imm[2:0]);
      end
   end

endmodule

// ==== fb_mem_arbiter.sv ====
`timescale 1ns/1ps

module fb_mem_arbiter (
   input  logic                         i_clock,
   input  logic                         i_reset,
   input  logic                         i_wr_valid,
   input  fb_pkg::fb_write_t            i_wr,
   input  logic                         i_rd_en,
   input  logic [fb_pkg::FB_ADDR_W-1:0] i_rd_addr,
   output fb_pkg::fb_color_t            o_rd_data,
   output logic                         o_ram_en,
   output logic                         o_ram_we,
   output logic [fb_pkg::FB_ADDR_W-1:0] o_ram_addr,
   output fb_pkg::fb_color_t            o_ram_wdata,
   input  fb_pkg::fb_color_t            i_ram_rdata,
   output logic                         o_overflow
);

   fb_pkg::fb_write_t             queue [fb_pkg::WQ_DEPTH];
   logic [fb_pkg::WQ_PTR_W-1:0]   head;
   logic [fb_pkg::WQ_PTR_W-1:0]   tail;
   logic [fb_pkg::WQ_PTR_W:0]     count;
   logic                          wq_empty;
   logic                          wq_full;
   logic                          bypass;
   logic                          pop;
   logic                          push;
   logic                          drop;
   fb_pkg::fb_write_t             wr_sel;

   assign wq_empty = (count == '0);
   assign wq_full  = (count == (fb_pkg::WQ_PTR_W + 1)'(fb_pkg::WQ_DEPTH));

   // reads always win, queued writes go before the new one
   assign bypass = i_wr_valid && wq_empty && !i_rd_en;
   assign pop    = !i_rd_en && !wq_empty;
   assign push   = i_wr_valid && !bypass && !wq_full;
   assign drop   = i_wr_valid && !bypass && wq_full;

   assign wr_sel = bypass ? i_wr : queue[head];

   assign o_ram_en    = i_rd_en || bypass || pop;
   assign o_ram_we    = !i_rd_en && (bypass || pop);
   assign o_ram_addr  = i_rd_en ? i_rd_addr : wr_sel.addr;
   assign o_ram_wdata = wr_sel.color;
   assign o_rd_data   = i_ram_rdata;  // registered inside the RAM

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         head       <= '0;
         tail       <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         if (push) begin
            tail <= tail + 1'b1;
         end
         if (pop) begin
            head <= head + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (drop) begin
            o_overflow <= 1'b1;  // sticky
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (push) begin
         queue[tail] <= i_wr;
      end
   end

endmodule

// ==== fb_ram.sv ====
`timescale 1ns/1ps

module fb_ram (
   input  logic                         i_clock,
   input  logic                         i_en,
   input  logic                         i_we,
   input  logic [fb_pkg::FB_ADDR_W-1:0] i_addr,
   input  fb_pkg::fb_color_t            i_wdata,
   output fb_pkg::fb_color_t            o_rdata
);

   fb_pkg::fb_color_t mem [fb_pkg::FB_DEPTH];

   always_ff @(posedge i_clock) begin
      if (i_en) begin
         if (i_we) begin
            mem[i_addr] <= i_wdata;
         end
         o_rdata <= mem[i_addr];  // read before write
      end
   end

endmodule

// ==== vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
   input  logic             i_clock,
   input  logic             i_reset,
   output fb_pkg::vga_pos_t o_pos
);

   logic [fb_pkg::CNT_W-1:0] h_cnt;
   logic [fb_pkg::CNT_W-1:0] v_cnt;
   logic                     h_last;
   logic                     v_last;
   logic                     h_vis;
   logic                     v_vis;
   logic                     h_sync;
   logic                     v_sync;

   assign h_last = (h_cnt == fb_pkg::CNT_W'(fb_pkg::H_TOTAL - 1));
   assign v_last = (v_cnt == fb_pkg::CNT_W'(fb_pkg::V_TOTAL - 1));

   assign h_vis = (h_cnt < fb_pkg::CNT_W'(fb_pkg::H_VISIBLE));
   assign v_vis = (v_cnt < fb_pkg::CNT_W'(fb_pkg::V_VISIBLE));

   // visible, front porch, sync, back porch
   assign h_sync = (h_cnt >= fb_pkg::CNT_W'(fb_pkg::H_VISIBLE + fb_pkg::H_FRONT)) &&
                   (h_cnt <  fb_pkg::CNT_W'(fb_pkg::H_VISIBLE + fb_pkg::H_FRONT +
                                            fb_pkg::H_SYNC));
   assign v_sync = (v_cnt >= fb_pkg::CNT_W'(fb_pkg::V_VISIBLE + fb_pkg::V_FRONT)) &&
                   (v_cnt <  fb_pkg::CNT_W'(fb_pkg::V_VISIBLE + fb_pkg::V_FRONT +
                                            fb_pkg::V_SYNC));

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_last) begin
         h_cnt <= '0;
         v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // registered so everything reads 0 during reset
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_pos <= '0;
      end else begin
         o_pos.h       <= h_cnt;
         o_pos.v       <= v_cnt;
         o_pos.visible <= h_vis && v_vis;
         o_pos.hsync   <= h_sync;
         o_pos.vsync   <= v_sync;
      end
   end

endmodule

// ==== vga_scanout.sv ====
`timescale 1ns/1ps

module vga_scanout (
   input  logic                         i_clock,
   input  logic                         i_reset,
   input  fb_pkg::vga_pos_t             i_pos,
   output logic                         o_rd_en,
   output logic [fb_pkg::FB_ADDR_W-1:0] o_rd_addr,
   input  fb_pkg::fb_color_t            i_rd_data,
   output fb_pkg::vga_out_t             o_vga
);

   logic [fb_pkg::CNT_W-1:0]        h_blk;
   logic [fb_pkg::CNT_W-1:0]        v_blk;
   logic                            rd_d1;
   fb_pkg::fb_color_t               color_q;
   logic [fb_pkg::SCAN_LATENCY-2:0] vis_d;
   logic [fb_pkg::SCAN_LATENCY-2:0] hsync_d;
   logic [fb_pkg::SCAN_LATENCY-2:0] vsync_d;
   logic                            vis_out;

   assign h_blk = i_pos.h >> fb_pkg::PIX_SCALE_LOG2;
   assign v_blk = i_pos.v >> fb_pkg::PIX_SCALE_LOG2;

   // one read per 4-pixel group
   assign o_rd_en   = i_pos.visible && (i_pos.h[fb_pkg::PIX_SCALE_LOG2-1:0] == '0);
   assign o_rd_addr = fb_pkg::FB_ADDR_W'(v_blk) * fb_pkg::FB_ADDR_W'(fb_pkg::FB_COLS)
                    + fb_pkg::FB_ADDR_W'(h_blk);

   assign vis_out = vis_d[fb_pkg::SCAN_LATENCY-2];

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         rd_d1   <= 1'b0;
         vis_d   <= '0;
         hsync_d <= '0;
         vsync_d <= '0;
      end else begin
         rd_d1   <= o_rd_en;
         vis_d   <= {vis_d[fb_pkg::SCAN_LATENCY-3:0], i_pos.visible};
         hsync_d <= {hsync_d[fb_pkg::SCAN_LATENCY-3:0], i_pos.hsync};
         vsync_d <= {vsync_d[fb_pkg::SCAN_LATENCY-3:0], i_pos.vsync};
      end
   end

   // held for the rest of the group
   always_ff @(posedge i_clock) begin
      if (rd_d1) begin
         color_q <= i_rd_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_vga <= '0;
      end else begin
         o_vga.hsync <= hsync_d[fb_pkg::SCAN_LATENCY-2];
         o_vga.vsync <= vsync_d[fb_pkg::SCAN_LATENCY-2];
         o_vga.color <= vis_out ? color_q : '0;  // blank outside visible area
      end
   end

endmodule

// ==== vga_fb_top.sv ====
`timescale 1ns/1ps

module vga_fb_top (
   input  logic              i_clock,
   input  logic              i_reset,
   input  fb_pkg::fb_instr_t i_instr,
   input  logic              i_instr_en,
   output fb_pkg::vga_out_t  o_vga,
   output logic              o_error,
   output logic              o_overflow
);

   logic                         wr_valid;
   fb_pkg::fb_write_t            wr;
   logic                         rd_en;
   logic [fb_pkg::FB_ADDR_W-1:0] rd_addr;
   fb_pkg::fb_color_t            rd_data;
   logic                         ram_en;
   logic                         ram_we;
   logic [fb_pkg::FB_ADDR_W-1:0] ram_addr;
   fb_pkg::fb_color_t            ram_wdata;
   fb_pkg::fb_color_t            ram_rdata;
   fb_pkg::vga_pos_t             pos;

   fb_instr_decoder u_decoder (
      .i_clock    (i_clock),
      .i_reset    (i_reset),
      .i_instr    (i_instr),
      .i_instr_en (i_instr_en),
      .o_wr_valid (wr_valid),
      .o_wr       (wr),
      .o_error    (o_error)
   );

   fb_mem_arbiter u_arbiter (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_wr_valid  (wr_valid),
      .i_wr        (wr),
      .i_rd_en     (rd_en),
      .i_rd_addr   (rd_addr),
      .o_rd_data   (rd_data),
      .o_ram_en    (ram_en),
      .o_ram_we    (ram_we),
      .o_ram_addr  (ram_addr),
      .o_ram_wdata (ram_wdata),
      .i_ram_rdata (ram_rdata),
      .o_overflow  (o_overflow)
   );

   fb_ram u_ram (
      .i_clock (i_clock),
      .i_en    (ram_en),
      .i_we    (ram_we),
      .i_addr  (ram_addr),
      .i_wdata (ram_wdata),
      .o_rdata (ram_rdata)
   );

   vga_timing u_timing (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .o_pos   (pos)
   );

   vga_scanout u_scanout (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_pos     (pos),
      .o_rd_en   (rd_en),
      .o_rd_addr (rd_addr),
      .i_rd_data (rd_data),
      .o_vga     (o_vga)
   );

endmodule

// ==== vga_fb_sva.sv ====
`timescale 1ns/1ps

module vga_fb_sva (
   input logic             i_clock,
   input logic             i_reset,
   input fb_pkg::vga_out_t i_vga,
   input fb_pkg::vga_pos_t i_pos,
   input logic             i_error
);

   logic [7:0] hs_len;

   // cycles hsync has been high so far
   always_ff @(posedge i_clock) begin
      if (i_reset || !i_vga.hsync) begin
         hs_len <= '0;
      end else begin
         hs_len <= hs_len + 1'b1;
      end
   end

   assert property (@(posedge i_clock) disable iff (i_reset)
      !$past(i_pos.visible, fb_pkg::SCAN_LATENCY) |-> i_vga.color == '0)
      else $error("colour not blanked outside the visible area");

   assert property (@(posedge i_clock) disable iff (i_reset)
      $fell(i_vga.hsync) |-> hs_len == 8'(fb_pkg::H_SYNC))
      else $error("hsync pulse length wrong");

   assert property (@(posedge i_clock) $fell(i_error) |-> $past(i_reset))
      else $error("o_error fell without reset");

endmodule

bind vga_fb_top vga_fb_sva u_sva (
   .i_clock (i_clock),
   .i_reset (i_reset),
   .i_vga   (o_vga),
   .i_pos   (pos),
   .i_error (o_error)
);

// ==== tb_vga_fb.sv ====
`timescale 1ns/1ps

module tb_vga_fb;

   localparam int WAIT_LIMIT = 2 * fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;

   logic              clock;
   logic              reset;
   fb_pkg::fb_instr_t instr;
   logic              instr_en;
   fb_pkg::vga_out_t  vga;
   logic              error;
   logic              overflow;

   fb_pkg::fb_color_t model_fb [fb_pkg::FB_DEPTH];
   logic [7:0]        m_row;
   logic [7:0]        m_col;
   logic              m_err;
   int                err_cnt;
   int                test_cnt;
   int                pass_cnt;

   vga_fb_top i_dut (
      .i_clock    (clock),
      .i_reset    (reset),
      .i_instr    (instr),
      .i_instr_en (instr_en),
      .o_vga      (vga),
      .o_error    (error),
      .o_overflow (overflow)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   task automatic check_color(input fb_pkg::fb_color_t got, input fb_pkg::fb_color_t exp,
                              input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_vga_sync(input fb_pkg::vga_out_t got, input fb_pkg::vga_out_t exp,
                                 input string what);
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp) begin
         err_cnt++;
         $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   // xor of all five 3-bit slices of the address
   function automatic fb_pkg::fb_color_t fill_color(input int addr);
      logic [14:0] a;
      a = 15'(addr);
      return fb_pkg::fb_color_t'(a[2:0] ^ a[5:3] ^ a[8:6] ^ a[11:9] ^ a[14:12]);
   endfunction

   task automatic apply_reset();
      reset    = 1'b1;
      instr_en = 1'b0;
      repeat (5) @(posedge clock);
      #1;
      reset = 1'b0;
      m_row = '0;
      m_col = '0;
      m_err = 1'b0;
   endtask

   // drives one strobe and updates the model
   task automatic send(input logic [3:0] op, input logic [7:0] imm);
      logic [fb_pkg::FB_ADDR_W-1:0] addr;
      @(posedge clock);
      #1;
      instr.opcode = op;
      instr.imm    = imm;
      instr_en     = 1'b1;
      addr = fb_pkg::FB_ADDR_W'(int'(m_row) * fb_pkg::FB_COLS + int'(m_col));
      if (!m_err) begin
         case (op)
            fb_pkg::OP_NOP: ;
            fb_pkg::OP_LDR: m_row = imm;
            fb_pkg::OP_LDC: m_col = imm;
            fb_pkg::OP_LDD: begin
               if (m_row < 8'(fb_pkg::FB_ROWS) && m_col < 8'(fb_pkg::FB_COLS)) begin
                  model_fb[addr] = fb_pkg::fb_color_t'(imm[2:0]);
               end
            end
            default: begin
               m_err = 1'b1;
               m_row = '0;
               m_col = '0;
            end
         endcase
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge clock);
         #1;
         instr_en = 1'b0;
      end
   endtask

   task automatic wait_sync(input bit vert, input logic level, output int cycles);
      logic s;
      cycles = 0;
      do begin
         @(negedge clock);
         cycles++;
         s = vert ? vga.vsync : vga.hsync;
         if (cycles > WAIT_LIMIT) begin
            $display("timeout: %s never reached level %0b", vert ? "vsync" : "hsync", level);
            $display("Errors found");
            $finish;
         end
      end while (s !== level);
   endtask

   task automatic hsync_fall();
      int n;
      wait_sync(1'b0, 1'b1, n);
      wait_sync(1'b0, 1'b0, n);
   endtask

   // first pixel of every 4-pixel group in the next frame
   task automatic verify_frame();
      int n;
      logic [fb_pkg::FB_ADDR_W-1:0] addr;
      wait_sync(1'b1, 1'b1, n);
      wait_sync(1'b1, 1'b0, n);
      repeat (fb_pkg::V_BACK - 1) hsync_fall();  // last back porch fall leads line 0
      for (int v = 0; v < fb_pkg::V_VISIBLE; v++) begin
         hsync_fall();
         repeat (fb_pkg::H_BACK) @(negedge clock);
         for (int h = 0; h < fb_pkg::H_VISIBLE; h += 4) begin
            addr = fb_pkg::FB_ADDR_W'((v >> 2) * fb_pkg::FB_COLS + (h >> 2));
            check_color(vga.color, model_fb[addr], $sformatf("pixel (%0d,%0d)", h, v));
            repeat (4) @(negedge clock);
         end
      end
   endtask

   task automatic end_test(input string name, input int errs_before);
      test_cnt++;
      if (err_cnt == errs_before) begin
         pass_cnt++;
      end
      $display("test %0d %s: %s", test_cnt, name, (err_cnt == errs_before) ? "pass" : "fail");
   endtask

   initial begin
      int         n1;
      int         n2;
      int         errs;
      bit         last_ldd;
      logic [3:0] op;
      logic [7:0] imm;
      reset    = 1'b1;
      instr    = '0;
      instr_en = 1'b0;
      err_cnt  = 0;
      test_cnt = 0;
      pass_cnt = 0;
      void'($urandom(32'hb82bfe54));

      errs = err_cnt;
      apply_reset();
      @(negedge clock);
      check_vga_sync(vga, '0, "o_vga after reset");
      check_flag(error, 1'b0, "o_error after reset");
      check_flag(overflow, 1'b0, "o_overflow after reset");
      end_test("reset state", errs);

      errs = err_cnt;
      wait_sync(1'b0, 1'b0, n1);
      wait_sync(1'b0, 1'b1, n1);
      wait_sync(1'b0, 1'b0, n1);
      wait_sync(1'b0, 1'b1, n2);
      check_count(n1, fb_pkg::H_SYNC, "hsync high time");
      check_count(n1 + n2, fb_pkg::H_TOTAL, "hsync period");
      wait_sync(1'b1, 1'b0, n1);
      wait_sync(1'b1, 1'b1, n1);
      wait_sync(1'b1, 1'b0, n1);
      wait_sync(1'b1, 1'b1, n2);
      check_count(n1, fb_pkg::V_SYNC * fb_pkg::H_TOTAL, "vsync high time");
      check_count(n1 + n2, fb_pkg::V_TOTAL * fb_pkg::H_TOTAL, "frame length");
      end_test("sync timing", errs);

      errs = err_cnt;
      for (int r = 0; r < fb_pkg::FB_ROWS; r++) begin  // known contents everywhere
         send(fb_pkg::OP_LDR, 8'(r));
         for (int c = 0; c < fb_pkg::FB_COLS; c++) begin
            send(fb_pkg::OP_LDC, 8'(c));
            send(fb_pkg::OP_LDD, {5'd0, fill_color(r * fb_pkg::FB_COLS + c)});
         end
      end
      last_ldd = 1'b0;
      repeat (600) begin
         op = 4'($urandom_range(0, 3));
         if (last_ldd && op == fb_pkg::OP_LDD) begin
            op = fb_pkg::OP_NOP;
         end
         last_ldd = (op == fb_pkg::OP_LDD);
         if (op == fb_pkg::OP_LDR) begin
            imm = 8'($urandom_range(0, fb_pkg::FB_ROWS - 1));
         end else if (op == fb_pkg::OP_LDC) begin
            imm = 8'($urandom_range(0, fb_pkg::FB_COLS - 1));
         end else begin
            imm = 8'($urandom_range(0, 255));
         end
         send(op, imm);
      end
      idle(20);
      verify_frame();
      check_flag(overflow, 1'b0, "o_overflow after drawing");
      end_test("random drawing", errs);

      errs = err_cnt;
      repeat (20) begin
         send(fb_pkg::OP_LDR, 8'($urandom_range(0, fb_pkg::FB_ROWS - 1)));
         send(fb_pkg::OP_LDC, 8'($urandom_range(fb_pkg::FB_COLS, 255)));  // aliases next row
         send(fb_pkg::OP_LDD, 8'($urandom_range(0, 255)));
         send(fb_pkg::OP_LDR, 8'($urandom_range(fb_pkg::FB_ROWS, 255)));
         send(fb_pkg::OP_LDC, 8'($urandom_range(0, fb_pkg::FB_COLS - 1)));
         send(fb_pkg::OP_LDD, 8'($urandom_range(0, 255)));
      end
      idle(20);
      verify_frame();
      end_test("out-of-range writes", errs);

      errs = err_cnt;
      send(4'($urandom_range(4, 15)), 8'd0);
      idle(2);
      check_flag(error, 1'b1, "o_error after unknown opcode");
      repeat (10) begin
         send(fb_pkg::OP_LDR, 8'($urandom_range(0, fb_pkg::FB_ROWS - 1)));
         send(fb_pkg::OP_LDC, 8'($urandom_range(0, fb_pkg::FB_COLS - 1)));
         send(fb_pkg::OP_LDD, 8'($urandom_range(0, 255)));
      end
      idle(20);
      verify_frame();
      check_flag(error, 1'b1, "o_error held until reset");
      end_test("error state", errs);

      errs = err_cnt;
      idle(1);
      apply_reset();
      check_flag(error, 1'b0, "o_error after second reset");
      idle(3);  // counters restart on line 0, so the burst lands in visible pixels
      repeat (40) send(fb_pkg::OP_LDD, 8'($urandom_range(0, 255)));
      idle(4);
      check_flag(overflow, 1'b1, "o_overflow after write burst");
      end_test("queue overflow", errs);

      $display("%0d tests, %0d passed, %0d errors", test_cnt, pass_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
fb_pkg.sv
fb_instr_decoder.sv
fb_mem_arbiter.sv
fb_ram.sv
vga_timing.sv
vga_scanout.sv
vga_fb_top.sv
vga_fb_sva.sv
tb_vga_fb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_vga_fb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 0
PASS_MSG  ?= No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
